//--- decode_stage.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/alu_op_decoder.sv
rtl/mem_op_decoder.sv
rtl/flow_op_decoder.sv
rtl/decode_stage.sv
sim/decode_stage_tb.sv

//--- rtl/alu_op_decoder.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module alu_op_decoder
(
    input  logic [`DEC_INSTR_W-1:0] raw_instr,
    output logic                    hit,
    output decode_pkg::instr_op_t   op,
    output decode_pkg::alu_func_t   alu_func,
    output logic                    regwrite,
    output logic                    uses_rs1,
    output logic                    uses_rs2
);

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20; // SUB, SRA.
    localparam logic [5:0] F6_BASE = F7_BASE[6:1];
    localparam logic [5:0] F6_ALT  = F7_ALT[6:1];

    decode_pkg::opcode_t opc;
    logic [2:0]          f3;
    logic [6:0]          f7;
    logic [`DEC_F7_MSB-`DEC_SHAMT_HI_LSB:0] f6;

    assign opc = decode_pkg::opcode_t'(raw_instr[`DEC_OPC_MSB:`DEC_OPC_LSB]);
    assign f3  = raw_instr[`DEC_F3_MSB:`DEC_F3_LSB];
    assign f7  = raw_instr[`DEC_F7_MSB:`DEC_F7_LSB];
    assign f6  = raw_instr[`DEC_F7_MSB:`DEC_SHAMT_HI_LSB];

    always_comb
    begin
        op       = decode_pkg::UNKNOWN;
        alu_func = decode_pkg::ALU_NONE;
        case (opc)
            decode_pkg::OPC_OP_IMM:
            begin
                case (f3)
                    3'b000: {op, alu_func} = {decode_pkg::ADDI, decode_pkg::ALU_ADD};
                    3'b010: {op, alu_func} = {decode_pkg::SLTI, decode_pkg::ALU_SLT};
                    3'b011: {op, alu_func} = {decode_pkg::SLTIU, decode_pkg::ALU_SLTU};
                    3'b100: {op, alu_func} = {decode_pkg::XORI, decode_pkg::ALU_XOR};
                    3'b110: {op, alu_func} = {decode_pkg::ORI, decode_pkg::ALU_OR};
                    3'b111: {op, alu_func} = {decode_pkg::ANDI, decode_pkg::ALU_AND};
                    3'b001:
                    begin
                        if (f6 == F6_BASE)
                            {op, alu_func} = {decode_pkg::SLLI, decode_pkg::ALU_SLL};
                    end
                    default:
                    begin
                        if (f6 == F6_BASE)
                            {op, alu_func} = {decode_pkg::SRLI, decode_pkg::ALU_SRL};
                        else if (f6 == F6_ALT)
                            {op, alu_func} = {decode_pkg::SRAI, decode_pkg::ALU_SRA};
                    end
                endcase
            end
            decode_pkg::OPC_OP:
            begin
                if (f7 == F7_BASE)
                begin
                    case (f3)
                        3'b000: {op, alu_func} = {decode_pkg::ADD, decode_pkg::ALU_ADD};
                        3'b001: {op, alu_func} = {decode_pkg::SLL, decode_pkg::ALU_SLL};
                        3'b010: {op, alu_func} = {decode_pkg::SLT, decode_pkg::ALU_SLT};
                        3'b011: {op, alu_func} = {decode_pkg::SLTU, decode_pkg::ALU_SLTU};
                        3'b100: {op, alu_func} = {decode_pkg::XOR, decode_pkg::ALU_XOR};
                        3'b101: {op, alu_func} = {decode_pkg::SRL, decode_pkg::ALU_SRL};
                        3'b110: {op, alu_func} = {decode_pkg::OR, decode_pkg::ALU_OR};
                        default: {op, alu_func} = {decode_pkg::AND, decode_pkg::ALU_AND};
                    endcase
                end
                else if (f7 == F7_ALT)
                begin
                    if (f3 == 3'b000)
                        {op, alu_func} = {decode_pkg::SUB, decode_pkg::ALU_SUB};
                    else if (f3 == 3'b101)
                        {op, alu_func} = {decode_pkg::SRA, decode_pkg::ALU_SRA};
                end
                // M extension (funct7 01) falls through here.
            end
            default:
            begin
                op = decode_pkg::UNKNOWN;
            end
        endcase
    end

    assign hit      = (op != decode_pkg::UNKNOWN);
    assign regwrite = hit;
    assign uses_rs1 = hit;
    assign uses_rs2 = hit && (opc == decode_pkg::OPC_OP); // Immediates read rs1 only.

endmodule

//--- rtl/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

////////////////////////////////////////
// Widths
////////////////////////////////////////
`define DEC_INSTR_W       32
`define DEC_RADDR_W       5

////////////////////////////////////////
// Instruction field positions
////////////////////////////////////////
`define DEC_RD_LSB        7
`define DEC_OPC_LSB       0
`define DEC_OPC_MSB       (`DEC_RD_LSB - 1)
`define DEC_F3_LSB        12
`define DEC_F3_MSB        14
`define DEC_RS1_LSB       15
`define DEC_RS1_MSB       19
`define DEC_RS2_LSB       20
`define DEC_RS2_MSB       24
`define DEC_F7_LSB        25
`define DEC_F7_MSB        31
`define DEC_SHAMT_HI_LSB  26 // 6-bit shamt on RV64.

`endif

//--- rtl/decode_pkg.sv
package decode_pkg;

    ////////////////////////////////////////
    // Major opcodes in bits 6:0
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    ////////////////////////////////////////
    // Decoded instruction identity
    ////////////////////////////////////////
    typedef enum logic [5:0] {
        UNKNOWN = 6'd0,   // Also the illegal marker.
        // Register-immediate.
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        // Register-register.
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        // Memory.
        LB, LH, LW, LD,
        LBU, LHU, LWU,
        SB, SH, SW, SD,
        // Control flow.
        BEQ, BNE, BLT, BGE,
        BLTU, BGEU,
        JAL,
        JALR,
        LUI,
        AUIPC
    } instr_op_t;

    ////////////////////////////////////////
    // ALU function
    ////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_NONE = 4'd0,  // Branch compare only.
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LINK          // pc + 4 for jumps.
    } alu_func_t;

endpackage

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [`DEC_INSTR_W-1:0] raw_instr,
    output logic                    out_valid,
    output decode_pkg::instr_op_t   op,
    output decode_pkg::alu_func_t   alu_func,
    output logic                    regwrite,
    output logic                    memread,
    output logic                    memwrite,
    output logic                    branch,
    output logic                    illegal,
    output logic [`DEC_RADDR_W-1:0] ra1,
    output logic [`DEC_RADDR_W-1:0] ra2
);

    ////////////////////////////////////////
    // Group decoders
    ////////////////////////////////////////
    logic                  alu_hit;
    decode_pkg::instr_op_t alu_op;
    decode_pkg::alu_func_t alu_fn;
    logic                  alu_regwrite;
    logic                  alu_uses_rs1;
    logic                  alu_uses_rs2;

    logic                  mem_hit;
    decode_pkg::instr_op_t mem_op;
    logic                  mem_regwrite;
    logic                  mem_memread;
    logic                  mem_memwrite;
    logic                  mem_uses_rs2;

    logic                  flow_hit;
    decode_pkg::instr_op_t flow_op;
    decode_pkg::alu_func_t flow_fn;
    logic                  flow_regwrite;
    logic                  flow_branch;
    logic                  flow_uses_rs1;
    logic                  flow_uses_rs2;

    alu_op_decoder alu_op_decoder_inst
    (
        .raw_instr (raw_instr),
        .hit       (alu_hit),
        .op        (alu_op),
        .alu_func  (alu_fn),
        .regwrite  (alu_regwrite),
        .uses_rs1  (alu_uses_rs1),
        .uses_rs2  (alu_uses_rs2)
    );

    mem_op_decoder mem_op_decoder_inst
    (
        .raw_instr (raw_instr),
        .hit       (mem_hit),
        .op        (mem_op),
        .regwrite  (mem_regwrite),
        .memread   (mem_memread),
        .memwrite  (mem_memwrite),
        .uses_rs2  (mem_uses_rs2)
    );

    flow_op_decoder flow_op_decoder_inst
    (
        .raw_instr (raw_instr),
        .hit       (flow_hit),
        .op        (flow_op),
        .alu_func  (flow_fn),
        .regwrite  (flow_regwrite),
        .branch    (flow_branch),
        .uses_rs1  (flow_uses_rs1),
        .uses_rs2  (flow_uses_rs2)
    );

    ////////////////////////////////////////
    // Merge
    ////////////////////////////////////////
    decode_pkg::instr_op_t  op_d;
    decode_pkg::alu_func_t  func_d;
    logic                   regwrite_d;
    logic                   memread_d;
    logic                   memwrite_d;
    logic                   branch_d;
    logic                   use1_d;
    logic                   use2_d;
    logic                   illegal_d;
    logic [`DEC_RADDR_W-1:0] ra1_d;
    logic [`DEC_RADDR_W-1:0] ra2_d;

    always_comb
    begin
        op_d       = decode_pkg::UNKNOWN;
        func_d     = decode_pkg::ALU_NONE;
        regwrite_d = 1'b0;
        memread_d  = 1'b0;
        memwrite_d = 1'b0;
        branch_d   = 1'b0;
        use1_d     = 1'b0;
        use2_d     = 1'b0;
        if (alu_hit) // Groups are disjoint.
        begin
            op_d       = alu_op;
            func_d     = alu_fn;
            regwrite_d = alu_regwrite;
            use1_d     = alu_uses_rs1;
            use2_d     = alu_uses_rs2;
        end
        else if (mem_hit)
        begin
            op_d       = mem_op;
            func_d     = decode_pkg::ALU_ADD; // Address add.
            regwrite_d = mem_regwrite;
            memread_d  = mem_memread;
            memwrite_d = mem_memwrite;
            use1_d     = 1'b1;
            use2_d     = mem_uses_rs2;
        end
        else if (flow_hit)
        begin
            op_d       = flow_op;
            func_d     = flow_fn;
            regwrite_d = flow_regwrite;
            branch_d   = flow_branch;
            use1_d     = flow_uses_rs1;
            use2_d     = flow_uses_rs2;
        end
    end

    assign illegal_d = !(alu_hit || mem_hit || flow_hit);
    assign ra1_d     = use1_d ? raw_instr[`DEC_RS1_MSB:`DEC_RS1_LSB] : '0;
    assign ra2_d     = use2_d ? raw_instr[`DEC_RS2_MSB:`DEC_RS2_LSB] : '0;

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            op        <= decode_pkg::UNKNOWN;
            alu_func  <= decode_pkg::ALU_NONE;
            regwrite  <= 1'b0;
            memread   <= 1'b0;
            memwrite  <= 1'b0;
            branch    <= 1'b0;
            illegal   <= 1'b0;
            ra1       <= '0;
            ra2       <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            op        <= op_d;
            alu_func  <= func_d;
            regwrite  <= in_valid && regwrite_d; // Bubble writes nothing.
            memread   <= in_valid && memread_d;
            memwrite  <= in_valid && memwrite_d;
            branch    <= in_valid && branch_d;
            illegal   <= in_valid && illegal_d;
            ra1       <= ra1_d;
            ra2       <= ra2_d;
        end
    end

endmodule

//--- rtl/flow_op_decoder.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module flow_op_decoder
(
    input  logic [`DEC_INSTR_W-1:0] raw_instr,
    output logic                    hit,
    output decode_pkg::instr_op_t   op,
    output decode_pkg::alu_func_t   alu_func,
    output logic                    regwrite,
    output logic                    branch,
    output logic                    uses_rs1,
    output logic                    uses_rs2
);

    decode_pkg::opcode_t opc;
    logic [2:0]          f3;

    assign opc = decode_pkg::opcode_t'(raw_instr[`DEC_OPC_MSB:`DEC_OPC_LSB]);
    assign f3  = raw_instr[`DEC_F3_MSB:`DEC_F3_LSB];

    always_comb
    begin
        op       = decode_pkg::UNKNOWN;
        alu_func = decode_pkg::ALU_NONE;
        regwrite = 1'b0;
        branch   = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opc)
            decode_pkg::OPC_BRANCH:
            begin
                case (f3)
                    3'd0:    op = decode_pkg::BEQ;
                    3'd1:    op = decode_pkg::BNE;
                    3'd4:    op = decode_pkg::BLT;
                    3'd5:    op = decode_pkg::BGE;
                    3'd6:    op = decode_pkg::BLTU;
                    3'd7:    op = decode_pkg::BGEU;
                    default: op = decode_pkg::UNKNOWN; // Gap at 2 and 3.
                endcase
                if (op != decode_pkg::UNKNOWN)
                begin
                    branch   = 1'b1;
                    uses_rs1 = 1'b1;
                    uses_rs2 = 1'b1;
                end
            end
            decode_pkg::OPC_JAL:
            begin
                op       = decode_pkg::JAL;
                alu_func = decode_pkg::ALU_LINK;
                regwrite = 1'b1;
                branch   = 1'b1;
            end
            decode_pkg::OPC_JALR:
            begin
                if (f3 == 3'd0)
                begin
                    op       = decode_pkg::JALR;
                    alu_func = decode_pkg::ALU_LINK;
                    regwrite = 1'b1;
                    branch   = 1'b1;
                    uses_rs1 = 1'b1; // Jump base.
                end
            end
            decode_pkg::OPC_LUI:
            begin
                op       = decode_pkg::LUI;
                alu_func = decode_pkg::ALU_ADD;
                regwrite = 1'b1;
            end
            decode_pkg::OPC_AUIPC:
            begin
                op       = decode_pkg::AUIPC;
                alu_func = decode_pkg::ALU_ADD;
                regwrite = 1'b1;
            end
            default:
            begin
                op = decode_pkg::UNKNOWN;
            end
        endcase
    end

    assign hit = (op != decode_pkg::UNKNOWN);

endmodule

//--- rtl/mem_op_decoder.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module mem_op_decoder
(
    input  logic [`DEC_INSTR_W-1:0] raw_instr,
    output logic                    hit,
    output decode_pkg::instr_op_t   op,
    output logic                    regwrite,
    output logic                    memread,
    output logic                    memwrite,
    output logic                    uses_rs2
);

    decode_pkg::opcode_t opc;
    logic [2:0]          f3;
    logic                is_load;

    assign opc = decode_pkg::opcode_t'(raw_instr[`DEC_OPC_MSB:`DEC_OPC_LSB]);
    assign f3  = raw_instr[`DEC_F3_MSB:`DEC_F3_LSB];

    always_comb
    begin
        op = decode_pkg::UNKNOWN;
        case (opc)
            decode_pkg::OPC_LOAD:
            begin
                case (f3)
                    3'd0:    op = decode_pkg::LB;
                    3'd1:    op = decode_pkg::LH;
                    3'd2:    op = decode_pkg::LW;
                    3'd3:    op = decode_pkg::LD;
                    3'd4:    op = decode_pkg::LBU;
                    3'd5:    op = decode_pkg::LHU;
                    3'd6:    op = decode_pkg::LWU;
                    default: op = decode_pkg::UNKNOWN; // No LDU.
                endcase
            end
            decode_pkg::OPC_STORE:
            begin
                case (f3)
                    3'd0:    op = decode_pkg::SB;
                    3'd1:    op = decode_pkg::SH;
                    3'd2:    op = decode_pkg::SW;
                    3'd3:    op = decode_pkg::SD;
                    default: op = decode_pkg::UNKNOWN;
                endcase
            end
            default:
            begin
                op = decode_pkg::UNKNOWN;
            end
        endcase
    end

    assign is_load  = (opc == decode_pkg::OPC_LOAD);
    assign hit      = (op != decode_pkg::UNKNOWN);
    assign regwrite = hit && is_load;
    assign memread  = hit && is_load;
    assign memwrite = hit && !is_load;
    assign uses_rs2 = memwrite; // Store data.

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds and runs the decode stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f decode_stage.f --top-module decode_stage_tb \
    -Mdir obj_dir > "$LOG" 2>&1 &&
    ./obj_dir/Vdecode_stage_tb >> "$LOG" 2>&1 ||
    { cat "$LOG"; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "TESTS FAILED" "$LOG" && exit 1 || exit 0

//--- sim/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_tb;

    localparam int          TIMEOUT    = 16;
    localparam int          STREAM_LEN = 400;
    localparam logic [31:0] SEED       = 32'hf2331497;

    ////////////////////////////////////////
    // Decode tables indexed by funct3
    ////////////////////////////////////////
    localparam decode_pkg::instr_op_t IMM_IDS [8] = '{decode_pkg::ADDI, decode_pkg::SLLI,
        decode_pkg::SLTI, decode_pkg::SLTIU, decode_pkg::XORI, decode_pkg::SRLI,
        decode_pkg::ORI, decode_pkg::ANDI};
    localparam decode_pkg::instr_op_t REG_IDS [8] = '{decode_pkg::ADD, decode_pkg::SLL,
        decode_pkg::SLT, decode_pkg::SLTU, decode_pkg::XOR, decode_pkg::SRL,
        decode_pkg::OR, decode_pkg::AND};
    localparam decode_pkg::instr_op_t LOAD_IDS [8] = '{decode_pkg::LB, decode_pkg::LH,
        decode_pkg::LW, decode_pkg::LD, decode_pkg::LBU, decode_pkg::LHU, decode_pkg::LWU,
        decode_pkg::UNKNOWN};
    localparam decode_pkg::instr_op_t STORE_IDS [4] = '{decode_pkg::SB, decode_pkg::SH,
        decode_pkg::SW, decode_pkg::SD};
    localparam decode_pkg::instr_op_t BR_IDS [8] = '{decode_pkg::BEQ, decode_pkg::BNE,
        decode_pkg::UNKNOWN, decode_pkg::UNKNOWN, decode_pkg::BLT, decode_pkg::BGE,
        decode_pkg::BLTU, decode_pkg::BGEU};
    localparam decode_pkg::alu_func_t ALU_FNS [8] = '{decode_pkg::ALU_ADD, decode_pkg::ALU_SLL,
        decode_pkg::ALU_SLT, decode_pkg::ALU_SLTU, decode_pkg::ALU_XOR, decode_pkg::ALU_SRL,
        decode_pkg::ALU_OR, decode_pkg::ALU_AND};
    localparam logic [6:0] OPC_TAB [16] = '{decode_pkg::OPC_OP_IMM, decode_pkg::OPC_OP,
        decode_pkg::OPC_LOAD, decode_pkg::OPC_STORE, decode_pkg::OPC_BRANCH,
        decode_pkg::OPC_JAL, decode_pkg::OPC_JALR, decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC,
        decode_pkg::OPC_OP_IMM, decode_pkg::OPC_LOAD, decode_pkg::OPC_STORE,
        decode_pkg::OPC_BRANCH, 7'h3b, 7'h1b, 7'h00}; // Last three are dropped groups.

    typedef struct packed {
        logic                    valid;
        decode_pkg::instr_op_t   op;
        decode_pkg::alu_func_t   func;
        logic                    regwrite;
        logic                    memread;
        logic                    memwrite;
        logic                    branch;
        logic                    illegal;
        logic [`DEC_RADDR_W-1:0] ra1;
        logic [`DEC_RADDR_W-1:0] ra2;
    } exp_t;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic [`DEC_INSTR_W-1:0] raw_instr;
    logic                    out_valid;
    decode_pkg::instr_op_t   op;
    decode_pkg::alu_func_t   alu_func;
    logic                    regwrite;
    logic                    memread;
    logic                    memwrite;
    logic                    branch;
    logic                    illegal;
    logic [`DEC_RADDR_W-1:0] ra1;
    logic [`DEC_RADDR_W-1:0] ra2;

    exp_t        exp_q[$];
    logic [31:0] lfsr;
    int          errors;
    int          checks;

    decode_stage decode_stage_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .raw_instr (raw_instr),
        .out_valid (out_valid),
        .op        (op),
        .alu_func  (alu_func),
        .regwrite  (regwrite),
        .memread   (memread),
        .memwrite  (memwrite),
        .branch    (branch),
        .illegal   (illegal),
        .ra1       (ra1),
        .ra2       (ra2)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Random numbers and encoding
    ////////////////////////////////////////
    function automatic logic lfsr_step();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1.
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_step()};
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = rand_bits(5);
        return (r[4:0] == 5'd0) ? 5'd1 : r[4:0]; // Keeps masking visible.
    endfunction

    function automatic logic [6:0] rand_f7();
        logic [31:0] r;
        r = rand_bits(7);
        return r[6:0];
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    ////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////
    function automatic exp_t ref_decode(input logic v, input logic [`DEC_INSTR_W-1:0] w);
        exp_t                  e;
        logic [6:0]            opc;
        logic [2:0]            f3;
        logic [6:0]            f7;
        logic [5:0]            f6;
        logic                  legal;
        logic                  alt;
        logic                  u1;
        logic                  u2;
        logic                  rw;
        logic                  mr;
        logic                  mw;
        logic                  br;
        decode_pkg::instr_op_t id;
        decode_pkg::alu_func_t fn;
        opc   = w[`DEC_OPC_MSB:`DEC_OPC_LSB];
        f3    = w[`DEC_F3_MSB:`DEC_F3_LSB];
        f7    = w[`DEC_F7_MSB:`DEC_F7_LSB];
        f6    = w[`DEC_F7_MSB:`DEC_SHAMT_HI_LSB];
        legal = 1'b0;
        alt   = 1'b0;
        {u1, u2, rw, mr, mw, br} = '0;
        id    = decode_pkg::UNKNOWN;
        fn    = decode_pkg::ALU_NONE;
        case (opc)
            decode_pkg::OPC_OP_IMM:
            begin
                alt   = (f3 == 3'd5) && w[30];
                legal = (f3 == 3'd1) ? (f6 == 6'h00) :
                        (f3 == 3'd5) ? (f6 == 6'h00 || f6 == 6'h10) : 1'b1;
                id    = alt ? decode_pkg::SRAI : IMM_IDS[f3];
                fn    = alt ? decode_pkg::ALU_SRA : ALU_FNS[f3];
                {rw, u1} = 2'b11;
            end
            decode_pkg::OPC_OP:
            begin
                alt   = (f7 == 7'h20);
                legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
                id    = !alt ? REG_IDS[f3] : (f3 == 3'd0) ? decode_pkg::SUB : decode_pkg::SRA;
                fn    = !alt ? ALU_FNS[f3] :
                        (f3 == 3'd0) ? decode_pkg::ALU_SUB : decode_pkg::ALU_SRA;
                {rw, u1, u2} = 3'b111;
            end
            decode_pkg::OPC_LOAD:
            begin
                legal = (f3 != 3'd7);
                id    = LOAD_IDS[f3];
                fn    = decode_pkg::ALU_ADD;
                {rw, mr, u1} = 3'b111;
            end
            decode_pkg::OPC_STORE:
            begin
                legal = !f3[2];
                id    = STORE_IDS[f3[1:0]];
                fn    = decode_pkg::ALU_ADD;
                {mw, u1, u2} = 3'b111;
            end
            decode_pkg::OPC_BRANCH:
            begin
                legal = (f3[2:1] != 2'b01);
                id    = BR_IDS[f3];
                {br, u1, u2} = 3'b111;
            end
            decode_pkg::OPC_JAL, decode_pkg::OPC_JALR:
            begin
                legal = (opc == decode_pkg::OPC_JAL) || (f3 == 3'd0);
                id    = (opc == decode_pkg::OPC_JAL) ? decode_pkg::JAL : decode_pkg::JALR;
                fn    = decode_pkg::ALU_LINK;
                {rw, br} = 2'b11;
                u1    = (opc == decode_pkg::OPC_JALR);
            end
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC:
            begin
                legal = 1'b1;
                id    = (opc == decode_pkg::OPC_LUI) ? decode_pkg::LUI : decode_pkg::AUIPC;
                fn    = decode_pkg::ALU_ADD;
                rw    = 1'b1;
            end
            default:
            begin
                legal = 1'b0;
            end
        endcase
        if (!legal)
        begin
            id = decode_pkg::UNKNOWN;
            fn = decode_pkg::ALU_NONE;
            {u1, u2, rw, mr, mw, br} = '0;
        end
        e          = '0;
        e.valid    = v;
        e.op       = id;
        e.func     = fn;
        e.regwrite = v && rw;
        e.memread  = v && mr;
        e.memwrite = v && mw;
        e.branch   = v && br;
        e.illegal  = v && !legal;
        e.ra1      = u1 ? w[`DEC_RS1_MSB:`DEC_RS1_LSB] : '0;
        e.ra2      = u2 ? w[`DEC_RS2_MSB:`DEC_RS2_LSB] : '0;
        return e;
    endfunction

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        checks++;
        assert (actv === expv)
        else
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h at %0t", name, expv, actv, $time);
        end
    endtask

    task automatic check_outputs;
        exp_t e;
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("No expected result was queued for the output at %0t", $time);
        end
        else
        begin
            e = exp_q.pop_front();
            check_field("out_valid", 32'(e.valid), 32'(out_valid));
            check_field("op", 32'(e.op), 32'(op));
            check_field("alu_func", 32'(e.func), 32'(alu_func));
            check_field("regwrite", 32'(e.regwrite), 32'(regwrite));
            check_field("memread", 32'(e.memread), 32'(memread));
            check_field("memwrite", 32'(e.memwrite), 32'(memwrite));
            check_field("branch", 32'(e.branch), 32'(branch));
            check_field("illegal", 32'(e.illegal), 32'(illegal));
            check_field("ra1", 32'(e.ra1), 32'(ra1));
            check_field("ra2", 32'(e.ra2), 32'(ra2));
            checks++;
            assert (out_valid || !(regwrite || memread || memwrite || branch || illegal))
            else
            begin
                errors++;
                $display("A flag is set while out_valid is low at %0t", $time);
            end
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    task automatic drive(input logic v, input logic [`DEC_INSTR_W-1:0] w);
        in_valid  = v;
        raw_instr = w;
        exp_q.push_back(ref_decode(v, w));
    endtask

    task automatic step(input logic v, input logic [`DEC_INSTR_W-1:0] w);
        drive(v, w);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic await_output;
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!out_valid && n < TIMEOUT);
        if (!out_valid)
        begin
            $display("Timed out after %0d cycles waiting for out_valid at %0t", n, $time);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
        else
        begin
            checks++;
            assert (n == 1)
            else
            begin
                errors++;
                $display("Latency was %0d cycles instead of one at %0t", n, $time);
            end
        end
    endtask

    task automatic send_valid(input logic [`DEC_INSTR_W-1:0] w);
        drive(1'b1, w);
        await_output();
        check_outputs();
        step(1'b0, ~w); // Bubble carrying a different word.
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] w;
        logic [2:0]  f3;
        lfsr      = SEED;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        raw_instr = '0;

        // Reset dominates a valid ADD at the input.
        repeat (4)
        begin
            @(negedge clk);
            in_valid  = 1'b1;
            raw_instr = encode(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, decode_pkg::OPC_OP);
            exp_q.push_back(ref_decode(1'b0, '0));
            check_outputs();
        end
        rst_n = 1'b1;
        step(1'b0, '0);

        for (int f = 0; f < 8; f++)
        begin
            f3 = 3'(f);
            r  = rand_bits(7);
            w  = encode((f3 == 3'd1 || f3 == 3'd5) ? {6'h00, r[0]} : r[6:0], rand_reg(),
                        rand_reg(), f3, rand_reg(), decode_pkg::OPC_OP_IMM);
            send_valid(w);
            if (f3 == 3'd5)
                send_valid(encode({6'h10, r[0]}, rand_reg(), rand_reg(), f3, rand_reg(),
                                  decode_pkg::OPC_OP_IMM)); // SRAI.
            send_valid(encode(7'h00, rand_reg(), rand_reg(), f3, rand_reg(), decode_pkg::OPC_OP));
            if (f3 == 3'd0 || f3 == 3'd5)
                send_valid(encode(7'h20, rand_reg(), rand_reg(), f3, rand_reg(),
                                  decode_pkg::OPC_OP));
        end

        for (int f = 0; f < 7; f++)
            send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'(f), rand_reg(),
                              decode_pkg::OPC_LOAD));
        for (int f = 0; f < 4; f++)
            send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'(f), rand_reg(),
                              decode_pkg::OPC_STORE));

        for (int f = 0; f < 8; f++)
            if (f != 2 && f != 3)
                send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'(f), rand_reg(),
                                  decode_pkg::OPC_BRANCH));
        r = rand_bits(3);
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), r[2:0], rand_reg(),
                          decode_pkg::OPC_JAL));
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'd0, rand_reg(),
                          decode_pkg::OPC_JALR));
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), r[2:0], rand_reg(),
                          decode_pkg::OPC_LUI));
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), r[2:0], rand_reg(),
                          decode_pkg::OPC_AUIPC));

        // Dropped groups and encoding gaps.
        send_valid(encode(7'h01, rand_reg(), rand_reg(), 3'd0, rand_reg(), decode_pkg::OPC_OP));
        send_valid(encode(7'h01, rand_reg(), rand_reg(), 3'd4, rand_reg(), decode_pkg::OPC_OP));
        send_valid(encode(7'h00, rand_reg(), rand_reg(), 3'd0, rand_reg(), 7'h3b)); // ADDW.
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'd0, rand_reg(), 7'h1b));
        send_valid(32'h0000_0000);
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'd7, rand_reg(),
                          decode_pkg::OPC_LOAD));
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'd2, rand_reg(),
                          decode_pkg::OPC_BRANCH));
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'd3, rand_reg(),
                          decode_pkg::OPC_BRANCH));
        send_valid(encode(rand_f7(), rand_reg(), rand_reg(), 3'd1, rand_reg(),
                          decode_pkg::OPC_JALR));
        send_valid(encode(7'h10, rand_reg(), rand_reg(), 3'd5, rand_reg(),
                          decode_pkg::OPC_OP_IMM)); // Bad shift funct6.
        send_valid(encode(7'h20, rand_reg(), rand_reg(), 3'd1, rand_reg(), decode_pkg::OPC_OP));

        // Back-to-back stream with random in_valid.
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            w = rand_bits(32);
            r = rand_bits(4);
            w[`DEC_OPC_MSB:`DEC_OPC_LSB] = OPC_TAB[r[3:0]];
            step(lfsr_step(), w);
        end
        step(1'b0, '0);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
